// File: alu_pkg.sv
package alu_pkg;

	//////////////////////////////////////////////////////////////
	// basic types
	//////////////////////////////////////////////////////////////

	typedef logic [15:0] word_t;			// datapath word, operands and result
	typedef logic [3:0]  opcode_t;			// 4-bit instruction opcode
	typedef logic [2:0]  flag_t;			// {N, V, Z}

	// flag bit positions inside flag_t
	localparam int FLAG_N = 2;
	localparam int FLAG_V = 1;
	localparam int FLAG_Z = 0;

	//////////////////////////////////////////////////////////////
	// opcode encodings
	//////////////////////////////////////////////////////////////

	// arithmetic / logic group, bit 3 clear
	localparam opcode_t OP_ADD    = 4'h0;		// saturating add
	localparam opcode_t OP_SUB    = 4'h1;		// saturating subtract
	localparam opcode_t OP_XOR    = 4'h2;
	localparam opcode_t OP_RED    = 4'h3;		// byte reduction
	localparam opcode_t OP_SLL    = 4'h4;		// shift left logical
	localparam opcode_t OP_SRA    = 4'h5;		// shift right arithmetic
	localparam opcode_t OP_ROR    = 4'h6;		// rotate right
	localparam opcode_t OP_PADDSB = 4'h7;		// parallel nibble add

	// memory, immediate load and control group, bit 3 set
	localparam opcode_t OP_LW     = 4'h8;		// load word, addr = (A & ~1) + (B >> 1)
	localparam opcode_t OP_SW     = 4'h9;		// store word, same address math
	localparam opcode_t OP_LLB    = 4'hA;		// load low byte
	localparam opcode_t OP_LHB    = 4'hB;		// load high byte
	localparam opcode_t OP_B      = 4'hC;		// branch, resolved elsewhere
	localparam opcode_t OP_BR     = 4'hD;		// branch register
	localparam opcode_t OP_PCS    = 4'hE;		// pc save
	localparam opcode_t OP_HLT    = 4'hF;		// halt

	//////////////////////////////////////////////////////////////
	// saturation limits
	//////////////////////////////////////////////////////////////

	// full word, signed 16 bit
	localparam word_t WORD_MAX = 16'h7FFF;
	localparam word_t WORD_MIN = 16'h8000;

	// single nibble lane for paddsb, signed 4 bit
	localparam logic [3:0] NIB_MAX = 4'h7;
	localparam logic [3:0] NIB_MIN = 4'h8;

endpackage

// File: alu_arith.sv
`timescale 1ns/1ps

module alu_arith import alu_pkg::*; (
	input  opcode_t opcode_i,
	input  word_t   operand_a_i,		// first operand or base address
	input  word_t   operand_b_i,		// second operand or encoded mem offset
	output word_t   addsub_o,		// saturated add/sub, also mem address
	output word_t   paddsb_o,		// four saturated nibble lanes
	output word_t   red_o,			// sign extended byte reduction
	output logic    neg_o,			// sign of saturated sum
	output logic    ovf_o			// signed overflow of add/sub
);

	//////////////////////////////////////////////////////////////
	// add / subtract with address adjust
	//////////////////////////////////////////////////////////////

	logic  mem_op;				// lw or sw
	logic  sub_op;				// subtract instead of add
	word_t add_a;				// operand a after alignment
	word_t add_b;				// operand b after offset decode
	word_t b_eff;				// b or its inverse for subtract
	word_t raw_sum;				// unsaturated result
	logic [16:0] wide_sum;			// exact sum, one bit wider

	assign mem_op = opcode_i[3];
	// memory ops always form base + offset, only sub uses bit 0 as mode
	assign sub_op = opcode_i[0] & ~opcode_i[3];

	always_comb begin
		// base addr must be word aligned
		add_a = mem_op ? {operand_a_i[15:1], 1'b0} : operand_a_i;
		// offset is stored doubled in the encoding, undo it
		add_b = mem_op ? {1'b0, operand_b_i[15:1]} : operand_b_i;

		b_eff   = sub_op ? ~add_b : add_b;
		raw_sum = add_a + b_eff + {15'd0, sub_op};	// two's complement subtract

		// overflow when both inputs agree in sign and the sum does not
		ovf_o = (add_a[15] == b_eff[15]) && (raw_sum[15] != add_a[15]);

		if (ovf_o)
			addsub_o = add_a[15] ? WORD_MIN : WORD_MAX;	// clamp toward input sign
		else
			addsub_o = raw_sum;

		neg_o = addsub_o[15];		// N taken after saturation

		// exact sum never wraps, it leaves the 16-bit range where its top bits differ
		wide_sum = {add_a[15], add_a}
			 + (sub_op ? -{add_b[15], add_b} : {add_b[15], add_b});
		assert (ovf_o == (wide_sum[16] != wide_sum[15]))
			else $error("alu_arith: overflow flag %b wrong for exact sum %h",
				    ovf_o, wide_sum);
		// a saturated sum sits on the rail of the exact sum's sign
		if (ovf_o)
			assert (addsub_o == (wide_sum[16] ? WORD_MIN : WORD_MAX))
				else $error("alu_arith: overflow clamped to wrong rail, sum %h",
					    addsub_o);
	end

	//////////////////////////////////////////////////////////////
	// paddsb, four independent nibble lanes
	//////////////////////////////////////////////////////////////

	// signed 4-bit add clamped to [-8, 7]
	function automatic logic [3:0] sat_nib(input logic [3:0] x, input logic [3:0] y);
		logic [3:0] s;
		s = x + y;
		if ((x[3] == y[3]) && (s[3] != x[3]))
			sat_nib = x[3] ? NIB_MIN : NIB_MAX;
		else
			sat_nib = s;
	endfunction

	genvar lane;
	generate
		for (lane = 0; lane < 4; lane++) begin : g_nib
			assign paddsb_o[4*lane +: 4] =
				sat_nib(operand_a_i[4*lane +: 4], operand_b_i[4*lane +: 4]);
		end
	endgenerate

	//////////////////////////////////////////////////////////////
	// red, sum of four signed bytes
	//////////////////////////////////////////////////////////////

	logic signed [9:0] red_sum;		// 4 x [-128,127] fits in 10 bits

	always_comb begin
		red_sum = {{2{operand_a_i[15]}}, operand_a_i[15:8]}	// a high byte
			+ {{2{operand_a_i[7]}}, operand_a_i[7:0]}	// a low byte
			+ {{2{operand_b_i[15]}}, operand_b_i[15:8]}	// b high byte
			+ {{2{operand_b_i[7]}}, operand_b_i[7:0]};	// b low byte
	end

	assign red_o = {{6{red_sum[9]}}, red_sum};	// sign extend to word

endmodule

// File: alu_shift_logic.sv
`timescale 1ns/1ps

module alu_shift_logic import alu_pkg::*; (
	input  opcode_t opcode_i,		// bits 1:0 pick the shift mode
	input  word_t   operand_a_i,		// value to shift, low byte kept by lhb
	input  word_t   operand_b_i,		// shift amount in 3:0, immediate byte in 7:0
	output word_t   shift_o,
	output word_t   xor_o,
	output word_t   llb_o,
	output word_t   lhb_o
);

	//////////////////////////////////////////////////////////////
	// barrel shifter, one stage per amount bit
	//////////////////////////////////////////////////////////////

	logic [1:0]  mode;			// 00 sll, 01 sra, else ror
	logic [3:0]  amt;			// shift amount 0..15
	word_t       stg1;			// after shift by 1
	word_t       stg2;			// after shift by 2
	word_t       stg4;			// after shift by 4
	word_t       shift_ref;		// single-step shift for the check
	logic [31:0] ror_pair;			// a twice over, rotate window

	assign mode = opcode_i[1:0];
	assign amt  = operand_b_i[3:0];

	// one fixed-distance stage, bypassed when en is low
	function automatic word_t shift_stage(input word_t d, input logic [1:0] m,
					      input int unsigned n, input logic en);
		word_t r;
		case (m)
			2'b00:   r = d << n;				// zero fill
			2'b01:   r = word_t'($signed(d) >>> n);		// sign fill
			default: r = (d >> n) | (d << (16 - n));	// wrap low bits to top
		endcase
		shift_stage = en ? r : d;
	endfunction

	always_comb begin
		stg1    = shift_stage(operand_a_i, mode, 1, amt[0]);
		stg2    = shift_stage(stg1, mode, 2, amt[1]);
		stg4    = shift_stage(stg2, mode, 4, amt[2]);
		shift_o = shift_stage(stg4, mode, 8, amt[3]);

		// staged result must match a one-step shift by the full amount
		ror_pair = {operand_a_i, operand_a_i} >> amt;
		case (mode)
			2'b00:   shift_ref = operand_a_i << amt;
			2'b01:   shift_ref = word_t'($signed(operand_a_i) >>> amt);
			default: shift_ref = ror_pair[15:0];
		endcase
		assert (shift_o == shift_ref)
			else $error("alu_shift_logic: %h shifted by %0d gave %h, expected %h",
				    operand_a_i, amt, shift_o, shift_ref);
	end

	//////////////////////////////////////////////////////////////
	// logic and byte loads
	//////////////////////////////////////////////////////////////

	assign xor_o = operand_a_i ^ operand_b_i;

	// llb keeps the upper byte of rd, imm goes low
	assign llb_o = {operand_a_i[15:8], operand_b_i[7:0]};
	// lhb keeps the lower byte of rd, imm goes high
	assign lhb_o = {operand_b_i[7:0], operand_a_i[7:0]};

endmodule

// File: alu_compute.sv
`timescale 1ns/1ps

module alu_compute import alu_pkg::*; (
	input  logic    clk_i,
	input  logic    arst_n_i,
	input  logic    vld_i,			// current op may write flags
	input  opcode_t opcode_i,
	input  word_t   operand_a_i,		// pass-through for control ops
	input  word_t   addsub_i,		// add, sub, lw, sw
	input  word_t   paddsb_i,
	input  word_t   red_i,
	input  word_t   shift_i,		// sll, sra, ror
	input  word_t   xor_i,
	input  word_t   llb_i,
	input  word_t   lhb_i,
	input  logic    neg_i,			// N from the adder
	input  logic    ovf_i,			// V from the adder
	output word_t   result_o,
	output flag_t   flag_o			// registered {N, V, Z}
);

	//////////////////////////////////////////////////////////////
	// result select
	//////////////////////////////////////////////////////////////

	always_comb begin
		case (opcode_i)
			OP_ADD, OP_SUB,
			OP_LW, OP_SW:            result_o = addsub_i;	// arith and addr calc
			OP_SLL, OP_SRA, OP_ROR:  result_o = shift_i;	// all shift ops
			OP_XOR:                  result_o = xor_i;
			OP_RED:                  result_o = red_i;
			OP_PADDSB:               result_o = paddsb_i;
			OP_LLB:                  result_o = llb_i;
			OP_LHB:                  result_o = lhb_i;
			default:                 result_o = operand_a_i;	// b, br, pcs, hlt
		endcase
	end

	//////////////////////////////////////////////////////////////
	// flag next value and write enables
	//////////////////////////////////////////////////////////////

	flag_t flag_d;				// candidate flags for this op
	flag_t flag_wen;			// per-bit write enable
	flag_t flag_q;				// flag register
	logic  is_addsub;			// add or sub only, not the mem forms

	assign flag_d[FLAG_N] = neg_i;
	assign flag_d[FLAG_V] = ovf_i;
	assign flag_d[FLAG_Z] = (result_o == '0);	// zero on the selected result

	assign is_addsub = (opcode_i == OP_ADD) || (opcode_i == OP_SUB);

	// Z for the low half of the opcode map, minus the packed ops
	assign flag_wen[FLAG_Z] = vld_i & ~opcode_i[3]
				 & (opcode_i != OP_RED) & (opcode_i != OP_PADDSB);
	assign flag_wen[FLAG_V] = vld_i & is_addsub;
	assign flag_wen[FLAG_N] = vld_i & is_addsub;

	//////////////////////////////////////////////////////////////
	// flag register
	//////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			flag_q <= '0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (flag_wen[i])
					flag_q[i] <= flag_d[i];	// bits not enabled hold
			end
		end
	end

	assign flag_o = flag_q;

	// N from the adder must agree with the sign of the result branches will see
	a_neg_sign: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		vld_i && is_addsub |=> flag_o[FLAG_N] == $past(result_o[15]))
		else $error("alu_compute: N flag disagrees with the result sign");

endmodule

// File: alu_top.sv
`timescale 1ns/1ps

module alu_top import alu_pkg::*; (
	input  logic    clk_i,
	input  logic    arst_n_i,
	input  logic    vld_i,			// op is real, allow flag write
	input  opcode_t opcode_i,
	input  word_t   operand_a_i,
	input  word_t   operand_b_i,
	output word_t   result_o,		// combinational, same cycle
	output flag_t   flag_o			// {N, V, Z}, one edge after vld
);

	// arithmetic unit results
	word_t addsub;
	word_t paddsb;
	word_t red;
	logic  neg;
	logic  ovf;

	// shift / logic unit results
	word_t shift;
	word_t xor_res;
	word_t llb;
	word_t lhb;

	//////////////////////////////////////////////////////////////
	// execution units, side by side on the same operands
	//////////////////////////////////////////////////////////////

	alu_arith u_arith (
		.opcode_i    (opcode_i),
		.operand_a_i (operand_a_i),
		.operand_b_i (operand_b_i),
		.addsub_o    (addsub),
		.paddsb_o    (paddsb),
		.red_o       (red),
		.neg_o       (neg),
		.ovf_o       (ovf)
	);

	alu_shift_logic u_shift_logic (
		.opcode_i    (opcode_i),
		.operand_a_i (operand_a_i),
		.operand_b_i (operand_b_i),
		.shift_o     (shift),
		.xor_o       (xor_res),
		.llb_o       (llb),
		.lhb_o       (lhb)
	);

	// result mux and flag register
	alu_compute u_compute (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.vld_i       (vld_i),
		.opcode_i    (opcode_i),
		.operand_a_i (operand_a_i),
		.addsub_i    (addsub),
		.paddsb_i    (paddsb),
		.red_i       (red),
		.shift_i     (shift),
		.xor_i       (xor_res),
		.llb_i       (llb),
		.lhb_i       (lhb),
		.neg_i       (neg),
		.ovf_i       (ovf),
		.result_o    (result_o),
		.flag_o      (flag_o)
	);

endmodule

// File: alu_tb.sv
`timescale 1ns/1ps

module alu_tb import alu_pkg::*; ();

	localparam int    CLK_HALF    = 20;		// 40 ns clock period
	localparam int    RST_CYCLES  = 2;
	localparam int    FIELDS      = 6;		// vld, opcode, a, b, result, flags
	localparam int    MAX_VEC     = 128;
	localparam int    RST_TIMEOUT = 10;		// rising edges allowed for reset release
	localparam int    RUN_TIMEOUT = MAX_VEC + 8;	// falling edges for the vector loop
	localparam string DATA_FILE   = "alu_testdata.mem";

	logic    clk;
	logic    arst_n;
	logic    vld;
	opcode_t opcode;
	word_t   operand_a;
	word_t   operand_b;
	word_t   result;
	flag_t   flags;

	word_t   vec_mem [0:FIELDS*MAX_VEC-1];	// flat table, FIELDS words per vector

	int      n_vec;
	int      err_result;
	int      err_flag;
	int      err_other;
	logic    aborted;

	alu_top dut_i (
		.clk_i       (clk),
		.arst_n_i    (arst_n),
		.vld_i       (vld),
		.opcode_i    (opcode),
		.operand_a_i (operand_a),
		.operand_b_i (operand_b),
		.result_o    (result),
		.flag_o      (flags)
	);

	//////////////////////////////////////////////////////////////
	// clock and reset
	//////////////////////////////////////////////////////////////

	initial clk = 1'b0;
	always #CLK_HALF clk = ~clk;

	initial begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(negedge clk);	// release on a falling edge
		arst_n = 1'b1;
	end

	//////////////////////////////////////////////////////////////
	// compare helpers
	//////////////////////////////////////////////////////////////

	task automatic check_result(input int idx, input word_t exp, input word_t act);
		if (act !== exp) begin
			err_result++;
			$display("mismatch at %0d ns: vector %0d result expected %h got %h",
				 $time, idx, exp, act);
		end
	endtask

	// idx -1 is the check right after reset
	task automatic check_flags(input int idx, input flag_t exp, input flag_t act);
		if (act !== exp) begin
			err_flag++;
			$display("mismatch at %0d ns: vector %0d flags NVZ expected %b got %b",
				 $time, idx, exp, act);
		end
	endtask

	task automatic apply_vector(input int idx);
		vld       = vec_mem[idx*FIELDS][0];
		opcode    = opcode_t'(vec_mem[idx*FIELDS + 1]);
		operand_a = vec_mem[idx*FIELDS + 2];
		operand_b = vec_mem[idx*FIELDS + 3];
	endtask

	//////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////

	initial begin
		int fd;
		int waited;
		int cycles;
		int idx;

		vld        = 1'b0;
		opcode     = OP_HLT;
		operand_a  = '0;
		operand_b  = '0;
		err_result = 0;
		err_flag   = 0;
		err_other  = 0;
		aborted    = 1'b0;
		n_vec      = 0;

		// probe the file first so a missing file gets a readable message
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			$display("error: could not open test data file %s", DATA_FILE);
			err_other++;
			aborted = 1'b1;
		end else begin
			$fclose(fd);
			for (int i = 0; i < FIELDS*MAX_VEC; i++)
				vec_mem[i] = 16'hE000 ^ word_t'(i);	// tag, never a legal vld word
			$readmemh(DATA_FILE, vec_mem);
			while (n_vec < MAX_VEC && vec_mem[n_vec*FIELDS][15:12] == 4'h0)
				n_vec++;
			if (n_vec == 0) begin
				$display("error: test data file %s holds no vectors", DATA_FILE);
				err_other++;
				aborted = 1'b1;
			end
		end

		// wait for reset release, sampled on the rising edge
		waited = 0;
		while (!aborted && arst_n !== 1'b1 && waited < RST_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (!aborted && arst_n !== 1'b1) begin
			$display("error: reset was never released");
			err_other++;
			aborted = 1'b1;
		end

		// one vector per falling edge, flags of the previous one checked first
		idx    = 0;
		cycles = 0;
		while (!aborted && idx <= n_vec) begin
			@(negedge clk);
			cycles++;
			if (idx == 0)
				check_flags(-1, 3'b000, flags);		// reset value
			else
				check_flags(idx - 1, flag_t'(vec_mem[(idx - 1)*FIELDS + 5]), flags);
			if (idx < n_vec) begin
				apply_vector(idx);
				#(CLK_HALF - 5);			// settle, still before the rising edge
				check_result(idx, vec_mem[idx*FIELDS + 4], result);
			end
			idx++;
			if (cycles >= RUN_TIMEOUT && idx <= n_vec) begin
				$display("error: vectors did not finish within %0d cycles", RUN_TIMEOUT);
				err_other++;
				aborted = 1'b1;
			end
		end

		$display("errors: result %0d, flags %0d, other %0d (%0d vectors)",
			 err_result, err_flag, err_other, n_vec);
		if (err_result + err_flag + err_other == 0 && !aborted)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: alu_testdata.mem
// columns: vld opcode operand_a operand_b exp_result exp_flags
// exp_flags is {N,V,Z} after the rising edge, hex 0..7
// saturating add / sub
1 0 1234 0001 1235 0
1 0 7FFF 0001 7FFF 2
1 0 8000 FFFF 8000 6
1 1 0005 0005 0000 1
1 1 8000 0001 8000 6
1 1 7FFF FFFF 7FFF 2
1 1 0003 0008 FFFB 4
// lw / sw address, base made even, offset halved, flags held
1 8 1235 0010 123C 4
1 9 4001 0007 4003 4
1 8 FFFF 0002 FFFF 4
// paddsb and red, flags held
1 7 1234 1111 2345 4
1 7 793F 3A41 7870 4
1 3 0102 0304 000A 4
1 3 8080 FF7F FF7E 4
// sll, only Z written
1 4 0001 0004 0010 4
1 4 8001 0001 0002 4
1 4 00FF 000C F000 4
1 4 0001 0010 0001 4
1 4 8000 0001 0000 5
// sra with sign fill
1 5 8000 000F FFFF 4
1 5 7F00 0004 07F0 4
1 5 F0F0 0000 F0F0 4
// ror
1 6 1234 0004 4123 4
1 6 8001 0001 C000 4
1 6 1234 000F 2468 4
1 6 ABCD 0008 CDAB 4
1 6 ABCD 0000 ABCD 4
// xor, llb, lhb
1 2 A5A5 A5A5 0000 5
1 A 1234 ABCD 12CD 5
1 B 1234 ABCD CD34 5
1 2 F0F0 0FF0 FF00 4
1 A 0012 FF00 0000 4
// pass-through opcodes
1 C 1357 2468 1357 4
1 D 0000 FFFF 0000 4
1 E BEEF 0001 BEEF 4
1 F 00A0 00B0 00A0 4
// valid gating, result shown but flags held when vld is low
0 0 0005 FFFB 0000 4
0 0 7FFF 0001 7FFF 4
1 0 0000 0000 0000 1
0 1 8000 0001 8000 1
0 4 8000 0001 0000 1

// File: src.f
alu_pkg.sv
alu_arith.sv
alu_shift_logic.sv
alu_compute.sv
alu_top.sv
alu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ALU testbench with Verilator, verdict taken from the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

rm -f "$LOG"

if ! verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module alu_tb -Mdir "$BUILD_DIR"; then
	echo "build failed"
	exit 1
fi

if ! "./$BUILD_DIR/Valu_tb" > "$LOG" 2>&1; then
	cat "$LOG"
	echo "simulation ended with an error status"
	exit 1
fi

cat "$LOG"

if grep -q "All tests passed" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
